// File: Makefile
TOP := ps2_host_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): src.f $(wildcard rtl/*.sv verif/*.sv)
	verilator --binary --timing --assert -j 0 -f src.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then echo "run failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" sim.log; then echo "run ended early"; exit 1; fi

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// File: rtl/ps2_cmd_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_cmd_dispatch (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  req_valid,
	input  ps2_host_pkg::cmd_req_t                req,
	output logic                                  req_ready,
	output logic [ps2_host_pkg::NUM_PORTS-1:0]    push,
	output logic [7:0]                            push_cmd,
	input  logic [ps2_host_pkg::NUM_PORTS-1:0]    credit_ret
);

	logic [ps2_host_pkg::CREDIT_W-1:0] credit [ps2_host_pkg::NUM_PORTS];
	logic                              accept;

	// ready follows the credit of the port named in the request
	assign req_ready = (credit[req.port] != '0);
	assign accept    = req_valid && req_ready;
	assign push_cmd  = req.command; // byte fans out to every port

	////////////////////////////////////////////////////////////
	// per-port credit counters
	////////////////////////////////////////////////////////////
	generate
		for (genvar i = 0; i < ps2_host_pkg::NUM_PORTS; i++) begin : g_credit

			assign push[i] = accept && (int'(req.port) == i);

			always_ff @(posedge clk or negedge reset) begin
				if (!reset) begin
					credit[i] <= ps2_host_pkg::CREDIT_W'(ps2_host_pkg::CMD_DEPTH);
				end else if (push[i] && !credit_ret[i]) begin
					credit[i] <= credit[i] - 1'b1;  // entry handed to port
				end else if (!push[i] && credit_ret[i]) begin
					credit[i] <= credit[i] + 1'b1;  // entry left port buffer
				end
			end

			// port must never return more entries than it was given
			credit_ovf_a: assert property (@(posedge clk) disable iff (!reset)
				credit_ret[i] && !push[i] |-> int'(credit[i]) < ps2_host_pkg::CMD_DEPTH)
				else $error("port %0d returned a credit while all credits held", i);

		end
	endgenerate

endmodule

`default_nettype wire

// File: rtl/ps2_cmd_tx.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_cmd_tx (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  logic [7:0]                command,
	input  logic                      clk_fall,
	input  logic                      clk_rise,
	input  logic                      data_in,
	output logic                      clk_drive_low,
	output logic                      data_drive_en,
	output logic                      data_out,
	output logic                      busy,
	output logic                      done,
	output ps2_host_pkg::tx_status_e  status
);

	ps2_host_pkg::tx_state_e state;
	logic [7:0]              shreg;     // lsb goes out next
	logic                    parity;
	logic [2:0]              bit_cnt;
	logic [$clog2(ps2_host_pkg::EDGE_TIMEOUT_CYCLES + 1)-1:0] timer;
	logic                    waiting;   // device is clocking
	logic                    edge_seen;
	logic                    timed_out;
	logic                    hold_end;

	assign waiting = state inside {
		ps2_host_pkg::START_BIT,
		ps2_host_pkg::DATA,
		ps2_host_pkg::PARITY,
		ps2_host_pkg::STOP,
		ps2_host_pkg::WAIT_ACK
	};
	assign edge_seen = clk_fall | clk_rise;
	assign timed_out = waiting && (int'(timer) >= ps2_host_pkg::EDGE_TIMEOUT_CYCLES);
	assign hold_end  = (state == ps2_host_pkg::HOLD_CLOCK) &&
		(int'(timer) == ps2_host_pkg::HOLD_CYCLES - 1);

	////////////////////////////////////////////////////////////
	// shared timer for the hold period and the per-edge watchdog
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			timer <= '0;
		end else if (state == ps2_host_pkg::HOLD_CLOCK) begin
			if (hold_end) begin
				timer <= '0;
			end else begin
				timer <= timer + 1'b1;
			end
		end else if (waiting && !edge_seen && !timed_out) begin
			timer <= timer + 1'b1;
		end else begin
			timer <= '0;  // idle or a device edge restarts the watch
		end
	end

	////////////////////////////////////////////////////////////
	// frame FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state  <= ps2_host_pkg::IDLE;
			status <= ps2_host_pkg::ST_ACKED;
		end else if (timed_out) begin
			state  <= ps2_host_pkg::DONE;  // lines drop in DONE
			status <= ps2_host_pkg::ST_TIMEOUT;
		end else begin
			unique case (state)
				ps2_host_pkg::IDLE: begin
					if (start) state <= ps2_host_pkg::HOLD_CLOCK;
				end
				ps2_host_pkg::HOLD_CLOCK: begin
					if (hold_end) state <= ps2_host_pkg::START_BIT;
				end
				ps2_host_pkg::START_BIT: begin
					if (clk_fall) state <= ps2_host_pkg::DATA;
				end
				ps2_host_pkg::DATA: begin
					if (clk_fall && bit_cnt == 3'd7) state <= ps2_host_pkg::PARITY;
				end
				ps2_host_pkg::PARITY: begin
					if (clk_fall) state <= ps2_host_pkg::STOP;
				end
				ps2_host_pkg::STOP: begin
					if (clk_fall) state <= ps2_host_pkg::WAIT_ACK;  // data released here
				end
				ps2_host_pkg::WAIT_ACK: begin
					if (clk_rise) begin
						state <= ps2_host_pkg::DONE;
						if (data_in) begin
							status <= ps2_host_pkg::ST_NO_ACK;
						end else begin
							status <= ps2_host_pkg::ST_ACKED;
						end
					end
				end
				ps2_host_pkg::DONE: begin
					state <= ps2_host_pkg::IDLE;
				end
				default: begin
					state <= ps2_host_pkg::IDLE;
				end
			endcase
		end
	end

	// data path latched at start and shifted per falling edge
	always_ff @(posedge clk) begin
		if (state == ps2_host_pkg::IDLE && start) begin
			shreg   <= command;
			parity  <= ~^command;  // odd over 9 bits
			bit_cnt <= '0;
		end else if (state == ps2_host_pkg::DATA && clk_fall) begin
			shreg   <= shreg >> 1;
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_comb begin
		clk_drive_low = (state == ps2_host_pkg::HOLD_CLOCK);
		data_drive_en = 1'b0;
		data_out      = 1'b1;
		unique case (state)
			ps2_host_pkg::START_BIT: begin
				data_drive_en = 1'b1;
				data_out      = 1'b0;
			end
			ps2_host_pkg::DATA: begin
				data_drive_en = 1'b1;
				data_out      = shreg[0];
			end
			ps2_host_pkg::PARITY: begin
				data_drive_en = 1'b1;
				data_out      = parity;
			end
			ps2_host_pkg::STOP: begin
				data_drive_en = 1'b1;
				data_out      = 1'b1;
			end
			default: begin
				data_drive_en = 1'b0;
				data_out      = 1'b1;
			end
		endcase
	end

	assign busy = (state != ps2_host_pkg::IDLE);
	assign done = (state == ps2_host_pkg::DONE);

	// inhibit lasts exactly the hold count
	hold_len_a: assert property (@(posedge clk) disable iff (!reset)
		$fell(clk_drive_low) |->
			$past(clk_drive_low, ps2_host_pkg::HOLD_CYCLES) &&
			!$past(clk_drive_low, ps2_host_pkg::HOLD_CYCLES + 1))
		else $error("clock hold period is not HOLD_CYCLES long");

endmodule

`default_nettype wire

// File: rtl/ps2_host_pkg.sv
`default_nettype none

package ps2_host_pkg;

	////////////////////////////////////////////////////////////
	// sizing, timing counts at 1 MHz system clock
	////////////////////////////////////////////////////////////
	localparam int NUM_PORTS = 2;              // keyboard + mouse
	localparam int PORT_W = 1;
	localparam int CMD_DEPTH = 2;              // buffer entries = credits per port
	localparam int CREDIT_W = 2;
	localparam int HOLD_CYCLES = 100;          // ~100 us clock inhibit
	localparam int EDGE_TIMEOUT_CYCLES = 2000; // max wait for any device edge

	typedef enum logic [3:0] {
		IDLE       = 4'd0,
		HOLD_CLOCK = 4'd1,
		START_BIT  = 4'd2,
		DATA       = 4'd3,
		PARITY     = 4'd4,
		STOP       = 4'd5,
		WAIT_ACK   = 4'd6,
		DONE       = 4'd7
	} tx_state_e;

	typedef enum logic [1:0] {
		ST_ACKED   = 2'd0,
		ST_NO_ACK  = 2'd1,
		ST_TIMEOUT = 2'd2
	} tx_status_e;

	typedef struct packed {
		logic [PORT_W-1:0] port;
		logic [7:0]        command;
	} cmd_req_t;

	typedef struct packed {
		logic [PORT_W-1:0] port;
		logic [7:0]        command;
		tx_status_e        status;
	} cmd_result_t;

endpackage

`default_nettype wire

// File: rtl/ps2_host_top.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_host_top (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  req_valid,
	input  ps2_host_pkg::cmd_req_t                req,
	output logic                                  req_ready,
	output logic                                  result_valid,
	output ps2_host_pkg::cmd_result_t             result,
	input  logic                                  result_ready,
	inout  wire  [ps2_host_pkg::NUM_PORTS-1:0]    ps2_clk,
	inout  wire  [ps2_host_pkg::NUM_PORTS-1:0]    ps2_data
);

	logic [ps2_host_pkg::NUM_PORTS-1:0]                   push;
	logic [7:0]                                           push_cmd;
	logic [ps2_host_pkg::NUM_PORTS-1:0]                   credit_ret;
	logic [ps2_host_pkg::NUM_PORTS-1:0]                   res_valid;
	logic [ps2_host_pkg::NUM_PORTS-1:0]                   res_ack;
	ps2_host_pkg::cmd_result_t [ps2_host_pkg::NUM_PORTS-1:0] res;

	ps2_cmd_dispatch u_dispatch (
		.clk        (clk),
		.reset      (reset),
		.req_valid  (req_valid),
		.req        (req),
		.req_ready  (req_ready),
		.push       (push),
		.push_cmd   (push_cmd),
		.credit_ret (credit_ret)
	);

	generate
		for (genvar i = 0; i < ps2_host_pkg::NUM_PORTS; i++) begin : g_port
			ps2_port u_port (
				.clk        (clk),
				.reset      (reset),
				.port_id    (ps2_host_pkg::PORT_W'(i)),  // own index, fixed per copy
				.push       (push[i]),
				.push_cmd   (push_cmd),
				.credit_ret (credit_ret[i]),
				.res_valid  (res_valid[i]),
				.res        (res[i]),
				.res_ack    (res_ack[i]),
				.ps2_clk    (ps2_clk[i]),
				.ps2_data   (ps2_data[i])
			);
		end
	endgenerate

	ps2_result_collect u_collect (
		.clk          (clk),
		.reset        (reset),
		.res_valid    (res_valid),
		.res          (res),
		.res_ack      (res_ack),
		.result_valid (result_valid),
		.result       (result),
		.result_ready (result_ready)
	);

endmodule

`default_nettype wire

// File: rtl/ps2_port.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_port (
	input  logic                              clk,
	input  logic                              reset,
	input  logic [ps2_host_pkg::PORT_W-1:0]   port_id,
	input  logic                              push,
	input  logic [7:0]                        push_cmd,
	output logic                              credit_ret,
	output logic                              res_valid,
	output ps2_host_pkg::cmd_result_t         res,
	input  logic                              res_ack,
	inout  wire                               ps2_clk,
	inout  wire                               ps2_data
);

	logic [7:0]                        cmd_mem [ps2_host_pkg::CMD_DEPTH];
	logic                              wr_ptr;       // two entries, one bit
	logic                              rd_ptr;
	logic [ps2_host_pkg::CREDIT_W-1:0] count;
	logic                              pop;
	logic                              start;
	logic [1:0]                        clk_sync;
	logic [1:0]                        data_sync;
	logic                              clk_prev;
	logic                              clk_fall;
	logic                              clk_rise;
	logic                              clk_drive_low;
	logic                              data_drive_en;
	logic                              data_out;
	logic                              busy;
	logic                              done;
	ps2_host_pkg::tx_status_e          status;
	ps2_host_pkg::tx_status_e          res_status;

	assign pop   = res_valid && res_ack;  // head entry retires with its result
	assign start = (count != '0) && !busy && !res_valid;

	always_ff @(posedge clk) begin
		if (push) begin
			cmd_mem[wr_ptr] <= push_cmd;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (!push && pop) begin
				count <= count - 1'b1;
			end
		end
	end

	// 2-flop sync, lines idle high
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];
	assign clk_rise = ~clk_prev & clk_sync[1];

	ps2_cmd_tx u_tx (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.command       (cmd_mem[rd_ptr]),
		.clk_fall      (clk_fall),
		.clk_rise      (clk_rise),
		.data_in       (data_sync[1]),
		.clk_drive_low (clk_drive_low),
		.data_drive_en (data_drive_en),
		.data_out      (data_out),
		.busy          (busy),
		.done          (done),
		.status        (status)
	);

	// open drain, only ever pull low
	assign ps2_clk  = clk_drive_low ? 1'b0 : 1'bz;
	assign ps2_data = (data_drive_en && !data_out) ? 1'b0 : 1'bz;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			res_valid  <= 1'b0;
			credit_ret <= 1'b0;
		end else begin
			credit_ret <= pop;
			if (done) begin
				res_valid <= 1'b1;
			end else if (res_ack) begin
				res_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (done) res_status <= status;
	end

	assign res = '{port: port_id, command: cmd_mem[rd_ptr], status: res_status};

endmodule

`default_nettype wire

// File: rtl/ps2_result_collect.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_result_collect (
	input  logic                                               clk,
	input  logic                                               reset,
	input  logic [ps2_host_pkg::NUM_PORTS-1:0]                 res_valid,
	input  ps2_host_pkg::cmd_result_t [ps2_host_pkg::NUM_PORTS-1:0] res,
	output logic [ps2_host_pkg::NUM_PORTS-1:0]                 res_ack,
	output logic                                               result_valid,
	output ps2_host_pkg::cmd_result_t                          result,
	input  logic                                               result_ready
);

	logic [ps2_host_pkg::PORT_W-1:0] rr_ptr;  // first port to look at
	logic [ps2_host_pkg::PORT_W-1:0] grant;
	logic                            grant_found;
	logic                            load;
	int                              idx;

	// round robin search starting at rr_ptr
	always_comb begin
		grant_found = 1'b0;
		grant       = rr_ptr;
		idx         = 0;
		for (int k = 0; k < ps2_host_pkg::NUM_PORTS; k++) begin
			idx = (int'(rr_ptr) + k) % ps2_host_pkg::NUM_PORTS;
			if (!grant_found && res_valid[idx]) begin
				grant_found = 1'b1;
				grant       = idx[ps2_host_pkg::PORT_W-1:0];
			end
		end
	end

	assign load = grant_found && (!result_valid || result_ready);

	always_comb begin
		res_ack        = '0;
		res_ack[grant] = load;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			result_valid <= 1'b0;
			rr_ptr       <= '0;
		end else if (load) begin
			result_valid <= 1'b1;
			if (int'(grant) == ps2_host_pkg::NUM_PORTS - 1) begin
				rr_ptr <= '0;
			end else begin
				rr_ptr <= grant + 1'b1;
			end
		end else if (result_ready) begin
			result_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) result <= res[grant];
	end

	// stalled output must not change
	hold_a: assert property (@(posedge clk) disable iff (!reset)
		result_valid && !result_ready |=> result_valid && $stable(result))
		else $error("result changed under back-pressure");

endmodule

`default_nettype wire

// File: src.f
rtl/ps2_host_pkg.sv
rtl/ps2_cmd_tx.sv
rtl/ps2_port.sv
rtl/ps2_cmd_dispatch.sv
rtl/ps2_result_collect.sv
rtl/ps2_host_top.sv
verif/ps2_device_model.sv
verif/ps2_host_tb.sv

// File: verif/ps2_device_model.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_device_model (
	input  logic       clk,
	input  logic       respond,    // low = never clock
	input  logic       ack,        // low = leave data high on the ack clock
	inout  wire        ps2_clk,
	inout  wire        ps2_data,
	output logic [7:0] rx_byte,
	output logic       rx_parity,
	output logic       rx_stop,
	output int         frame_cnt,
	output int         err_cnt
);

	logic clk_low;
	logic data_low;

	assign ps2_clk  = clk_low ? 1'b0 : 1'bz;
	assign ps2_data = data_low ? 1'b0 : 1'bz;

	task automatic half_period();
		repeat (40) @(posedge clk);
	endtask

	// low half then high half, data read just before the clock rises
	task automatic clock_bit(output logic bit_val);
		clk_low <= 1'b1;
		half_period();
		bit_val = ps2_data;
		clk_low <= 1'b0;
		half_period();
	endtask

	task automatic wait_release(output logic released);
		int waited;
		waited   = 0;
		released = 1'b0;
		while (!released && waited < 1000) begin
			@(negedge clk);
			if (ps2_clk === 1'b1) released = 1'b1;
			else waited++;
		end
		if (!released) begin
			err_cnt = err_cnt + 1;
			$display("device model: host kept the clock low for over 1000 cycles");
		end
	endtask

	task automatic receive_frame();
		logic [7:0] data;
		logic       b;
		logic       par;
		logic       stp;
		@(posedge clk);
		for (int i = 0; i < 8; i++) begin
			clock_bit(b);
			data[i] = b;  // lsb first
		end
		clock_bit(par);
		clock_bit(stp);
		rx_byte   <= data;
		rx_parity <= par;
		rx_stop   <= stp;
		frame_cnt <= frame_cnt + 1;
		// eleventh clock, device answers on data
		clk_low <= 1'b1;
		repeat (20) @(posedge clk);
		if (ack) data_low <= 1'b1;
		repeat (20) @(posedge clk);
		clk_low <= 1'b0;
		half_period();
		data_low <= 1'b0;
	endtask

	initial begin
		logic released;
		clk_low   = 1'b0;
		data_low  = 1'b0;
		rx_byte   = '0;
		rx_parity = 1'b0;
		rx_stop   = 1'b0;
		frame_cnt = 0;
		err_cnt   = 0;
		forever begin
			@(negedge clk);
			if (ps2_clk === 1'b0) begin
				wait_release(released);
				// request to send: clock let go with data held low
				if (released && ps2_data === 1'b0 && respond) receive_frame();
			end
		end
	end

endmodule

`default_nettype wire

// File: verif/ps2_host_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_host_tb;

	logic                               clk;
	logic                               reset;
	logic                               req_valid;
	ps2_host_pkg::cmd_req_t             req;
	logic                               req_ready;
	logic                               result_valid;
	ps2_host_pkg::cmd_result_t          result;
	logic                               result_ready;
	wire  [ps2_host_pkg::NUM_PORTS-1:0] ps2_clk;
	wire  [ps2_host_pkg::NUM_PORTS-1:0] ps2_data;

	logic       respond    [ps2_host_pkg::NUM_PORTS];
	logic       ack_mode   [ps2_host_pkg::NUM_PORTS];
	logic [7:0] rx_byte    [ps2_host_pkg::NUM_PORTS];
	logic       rx_parity  [ps2_host_pkg::NUM_PORTS];
	logic       rx_stop    [ps2_host_pkg::NUM_PORTS];
	int         frame_cnt  [ps2_host_pkg::NUM_PORTS];
	int         dev_err    [ps2_host_pkg::NUM_PORTS];
	int         frame_seen [ps2_host_pkg::NUM_PORTS];

	ps2_host_pkg::cmd_result_t exp_q   [ps2_host_pkg::NUM_PORTS][$];  // per port, request order
	logic [7:0]                frame_q [ps2_host_pkg::NUM_PORTS][$];

	int errors;
	int checks;
	int sent_total;
	int results_seen;
	int seed;

	ps2_host_top UUT (
		.clk          (clk),
		.reset        (reset),
		.req_valid    (req_valid),
		.req          (req),
		.req_ready    (req_ready),
		.result_valid (result_valid),
		.result       (result),
		.result_ready (result_ready),
		.ps2_clk      (ps2_clk),
		.ps2_data     (ps2_data)
	);

	generate
		for (genvar i = 0; i < ps2_host_pkg::NUM_PORTS; i++) begin : g_dev
			pullup (ps2_clk[i]);
			pullup (ps2_data[i]);
			ps2_device_model u_dev (
				.clk       (clk),
				.respond   (respond[i]),
				.ack       (ack_mode[i]),
				.ps2_clk   (ps2_clk[i]),
				.ps2_data  (ps2_data[i]),
				.rx_byte   (rx_byte[i]),
				.rx_parity (rx_parity[i]),
				.rx_stop   (rx_stop[i]),
				.frame_cnt (frame_cnt[i]),
				.err_cnt   (dev_err[i])
			);
		end
	endgenerate

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// reference model and compare tasks
	////////////////////////////////////////////////////////////
	function automatic ps2_host_pkg::cmd_result_t expected_result(
		input ps2_host_pkg::cmd_req_t r, input logic dev_respond, input logic dev_ack);
		ps2_host_pkg::cmd_result_t e;
		e.port    = r.port;
		e.command = r.command;
		if (!dev_respond) e.status = ps2_host_pkg::ST_TIMEOUT;  // device never clocks
		else if (dev_ack) e.status = ps2_host_pkg::ST_ACKED;
		else e.status = ps2_host_pkg::ST_NO_ACK;
		return e;
	endfunction

	task automatic check_result(input ps2_host_pkg::cmd_result_t got,
		input ps2_host_pkg::cmd_result_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] result got 0x%h expected 0x%h", got, want);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	task automatic check_count(input string name, input int got, input int want);
		checks++;
		if (got != want) begin
			errors++;
			$display("[ERROR] %s got 0x%h expected 0x%h", name, got, want);
		end
	endtask

	// negedge view is what the DUT sees at the next rising edge
	always @(negedge clk) begin : result_check
		ps2_host_pkg::cmd_result_t want;
		int p;
		if (reset && result_valid && result_ready) begin
			p = int'(result.port);
			results_seen++;
			if (exp_q[p].size() == 0) begin
				errors++;
				$display("result arrived on port %0d with no request pending", p);
			end else begin
				want = exp_q[p].pop_front();
				check_result(result, want);
			end
		end
	end

	always @(negedge clk) begin : frame_check
		logic [7:0] want;
		for (int p = 0; p < ps2_host_pkg::NUM_PORTS; p++) begin
			if (frame_cnt[p] != frame_seen[p]) begin
				frame_seen[p] = frame_cnt[p];
				if (frame_q[p].size() == 0) begin
					errors++;
					$display("device on port %0d received a frame nobody sent", p);
				end else begin
					want = frame_q[p].pop_front();
					check_byte("rx_byte", rx_byte[p], want);
					check_bit("rx_byte^rx_parity", ^{rx_byte[p], rx_parity[p]}, 1'b1);
					check_bit("rx_stop", rx_stop[p], 1'b1);
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////
	task automatic set_mode(input int p, input logic dev_respond, input logic dev_ack);
		@(posedge clk);
		respond[p]  <= dev_respond;
		ack_mode[p] <= dev_ack;
	endtask

	task automatic offer_req(input ps2_host_pkg::cmd_req_t r, input int limit,
		output logic accepted);
		int waited;
		ps2_host_pkg::cmd_result_t want;
		waited   = 0;
		accepted = 1'b0;
		@(posedge clk);
		req_valid <= 1'b1;
		req       <= r;
		while (!accepted && waited < limit) begin
			@(negedge clk);
			if (req_ready) accepted = 1'b1;  // transfer on the coming edge
			else waited++;
		end
		if (accepted) begin
			want = expected_result(r, respond[r.port], ack_mode[r.port]);
			exp_q[r.port].push_back(want);
			if (respond[r.port]) frame_q[r.port].push_back(r.command);
			sent_total++;
		end
		@(posedge clk);
		req_valid <= 1'b0;
	endtask

	task automatic send_req(input ps2_host_pkg::cmd_req_t r, input int limit);
		logic accepted;
		offer_req(r, limit, accepted);
		if (!accepted) begin
			errors++;
			$display("request to port %0d was not accepted in %0d cycles", r.port, limit);
		end
	endtask

	task automatic wait_valid(input int limit);
		int waited;
		waited = 0;
		while (!result_valid && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (!result_valid) begin
			errors++;
			$display("no result showed up within %0d cycles", limit);
		end
	endtask

	task automatic wait_drain(input int limit);
		int   waited;
		logic pending;
		waited  = 0;
		pending = 1'b1;
		while (pending && waited < limit) begin
			@(negedge clk);
			pending = 1'b0;
			for (int p = 0; p < ps2_host_pkg::NUM_PORTS; p++) begin
				if (exp_q[p].size() != 0 || frame_q[p].size() != 0) pending = 1'b1;
			end
			waited++;
		end
		if (pending) begin
			errors++;
			$display("outstanding commands did not finish within %0d cycles", limit);
		end
	endtask

	initial begin : stimulus
		ps2_host_pkg::cmd_req_t r;
		logic [31:0]            rnd;
		logic                   accepted;
		int                     n_acc;
		errors       = 0;
		checks       = 0;
		sent_total   = 0;
		results_seen = 0;
		seed         = 32'h4ad77d79;
		reset        = 1'b0;
		req_valid    = 1'b0;
		req          = '0;
		result_ready = 1'b1;
		for (int p = 0; p < ps2_host_pkg::NUM_PORTS; p++) begin
			respond[p]  = 1'b1;
			ack_mode[p] = 1'b1;
		end
		repeat (10) @(posedge clk);
		reset <= 1'b1;

		// idle state out of reset
		@(negedge clk);
		check_bit("req_ready", req_ready, 1'b1);
		check_bit("result_valid", result_valid, 1'b0);
		for (int p = 0; p < ps2_host_pkg::NUM_PORTS; p++) begin
			check_bit("ps2_clk", ps2_clk[p], 1'b1);
			check_bit("ps2_data", ps2_data[p], 1'b1);
		end

		// single acked command
		r = '{port: '0, command: 8'hf4};
		send_req(r, 100);
		wait_drain(5000);

		set_mode(1, 1'b1, 1'b0);  // nack on port 1
		r = '{port: 1'b1, command: 8'hed};
		send_req(r, 100);
		wait_drain(5000);
		set_mode(1, 1'b1, 1'b1);

		set_mode(0, 1'b0, 1'b0);  // silent device on port 0
		r = '{port: '0, command: 8'hff};
		send_req(r, 100);
		wait_drain(10000);
		@(negedge clk);
		check_bit("ps2_clk[0]", ps2_clk[0], 1'b1);
		check_bit("ps2_data[0]", ps2_data[0], 1'b1);
		set_mode(0, 1'b1, 1'b1);

		// random traffic, both ports acking
		for (int n = 0; n < 12; n++) begin
			rnd       = $random(seed);
			r.port    = rnd[ps2_host_pkg::PORT_W-1:0];
			r.command = rnd[15:8];
			send_req(r, 5000);
		end
		wait_drain(30000);

		////////////////////////////////////////////////////////////
		// back-pressure on the result stream
		////////////////////////////////////////////////////////////
		@(posedge clk);
		result_ready <= 1'b0;
		n_acc = 0;
		for (int n = 0; n <= ps2_host_pkg::CMD_DEPTH; n++) begin
			r = '{port: '0, command: 8'(8'h30 + n)};
			offer_req(r, 50, accepted);
			if (accepted) n_acc++;
		end
		check_count("accepted while stalled", n_acc, ps2_host_pkg::CMD_DEPTH);
		wait_valid(5000);
		repeat (200) @(posedge clk);  // hold the output stalled a while
		@(negedge clk);
		check_bit("result_valid", result_valid, 1'b1);
		@(posedge clk);
		result_ready <= 1'b1;
		wait_drain(10000);

		for (int p = 0; p < ps2_host_pkg::NUM_PORTS; p++) begin
			check_count("device model errors", dev_err[p], 0);
		end
		check_count("results received", results_seen, sent_total);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
